//--- design/cpu_pkg.sv
package cpu_pkg;

    // Machine word, also used for addresses and instructions
    typedef logic [31:0] word_t;

    typedef logic [3:0] reg_idx_t;  // 16 registers, r15 is the PC

    localparam reg_idx_t REG_ZERO = 4'd0;
    localparam reg_idx_t REG_PC   = 4'd15;

    // Fetch address after reset unless the top level overrides it
    localparam word_t DEFAULT_RESET_VECTOR = 32'h0000_1000;

    typedef enum logic [3:0] {
        OP_OR   = 4'h0,
        OP_AND  = 4'h1,
        OP_ADD  = 4'h2,
        OP_MUL  = 4'h3,
        OP_RSVD = 4'h4,  // Contributes zero
        OP_SHL  = 4'h5,
        OP_SLE  = 4'h6,  // Signed
        OP_EQ   = 4'h7,
        OP_NOR  = 4'h8,
        OP_NAND = 4'h9,
        OP_XOR  = 4'ha,
        OP_SUB  = 4'hb,
        OP_XNOR = 4'hc,  // X xor ~operand
        OP_SHR  = 4'hd,  // Logical
        OP_SGT  = 4'he,  // Signed
        OP_NE   = 4'hf
    } alu_op_e;

    // Bit 1 set means a store, bit 0 set means rhs is the address
    typedef enum logic [1:0] {
        DEREF_PLAIN   = 2'b00,  // Z <- rhs
        DEREF_LOAD    = 2'b01,  // Z <- [rhs]
        DEREF_STORE_Z = 2'b10,  // [Z] <- rhs
        DEREF_STORE_R = 2'b11   // [rhs] <- Z
    } deref_e;

    typedef enum logic [1:0] {
        CLASS_NORMAL  = 2'd0,
        CLASS_NOP     = 2'd1,
        CLASS_ILLEGAL = 2'd2
    } insn_class_e;

    // Decoder output, shared by sequencer, register file and execution unit
    typedef struct packed {
        insn_class_e insn_class;
        deref_e      deref;
        logic        imm_sel;   // Type bit, 1 swaps Y and the immediate
        reg_idx_t    z;
        reg_idx_t    x;
        reg_idx_t    y;
        alu_op_e     op;
        logic [11:0] imm;
    } decoded_insn_t;

endpackage

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              reset_n,    // Clock
    input  logic              i_reset_n,  // Sync reset, active high
    input  cpu_pkg::reg_idx_t i_x_idx,
    input  cpu_pkg::reg_idx_t i_y_idx,
    input  cpu_pkg::reg_idx_t i_z_idx,
    input  cpu_pkg::word_t    i_pc,
    input  logic              i_we,
    input  cpu_pkg::reg_idx_t i_wr_idx,
    input  cpu_pkg::word_t    i_wr_data,
    output cpu_pkg::word_t    o_x,
    output cpu_pkg::word_t    o_y,
    output cpu_pkg::word_t    o_z
);
    import cpu_pkg::*;

    word_t regs [1:14];     // Only the general-purpose registers are stored
    word_t rd_view [16];    // What every read port sees
    logic  wr_ok;

    // r0 and r15 are not stored here
    assign wr_ok = i_we && (i_wr_idx != REG_ZERO) && (i_wr_idx != REG_PC);

    always_ff @(posedge reset_n) begin
        if (i_reset_n) begin
            for (int i = 1; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    always_comb begin
        rd_view[0] = '0;        // Hardwired zero
        for (int i = 1; i < 15; i++) begin
            rd_view[i] = regs[i];
        end
        rd_view[15] = i_pc;     // PC alias
    end

    assign o_x = rd_view[i_x_idx];
    assign o_y = rd_view[i_y_idx];
    assign o_z = rd_view[i_z_idx];

endmodule

//--- design/insn_decode.sv
`timescale 1ns/1ps

// Instruction layout
//   [31]    0 for a normal instruction
//   [30]    type, [29:28] deref mode
//   [27:24] Z, [23:20] X, [19:16] Y, [15:12] op, [11:0] immediate
module insn_decode (
    input  cpu_pkg::word_t         i_insn,
    output cpu_pkg::decoded_insn_t o_dec
);
    import cpu_pkg::*;

    decoded_insn_t dec;
    logic          is_normal;

    assign is_normal = (i_insn[31] == 1'b0);

    always_comb begin
        // Register and op fields are unpacked for every class
        dec.z       = i_insn[27:24];
        dec.x       = i_insn[23:20];
        dec.y       = i_insn[19:16];
        dec.op      = alu_op_e'(i_insn[15:12]);
        dec.imm     = i_insn[11:0];
        dec.imm_sel = i_insn[30];

        casez (i_insn[31:28])
            4'b0???: dec.insn_class = CLASS_NORMAL;
            4'b1111: dec.insn_class = CLASS_ILLEGAL;
            default: dec.insn_class = CLASS_NOP;  // Reserved encodings, PC just advances
        endcase

        // No memory access unless the instruction is a normal one
        if (is_normal) begin
            dec.deref = deref_e'(i_insn[29:28]);
        end else begin
            dec.deref = DEREF_PLAIN;
        end
    end

    assign o_dec = dec;

endmodule

//--- design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  cpu_pkg::decoded_insn_t i_dec,
    input  cpu_pkg::word_t         i_x,
    input  cpu_pkg::word_t         i_y,
    output cpu_pkg::word_t         o_rhs
);
    import cpu_pkg::*;

    word_t      imm_ext;
    word_t      opnd;       // Right operand of the op
    word_t      addend;     // Term added after the op
    word_t      func;
    logic [4:0] shamt;

    assign imm_ext = {{20{i_dec.imm[11]}}, i_dec.imm};

    // Type 0 is X op Y + I, type 1 is X op I + Y
    assign opnd   = i_dec.imm_sel ? imm_ext : i_y;
    assign addend = i_dec.imm_sel ? i_y     : imm_ext;

    assign shamt = opnd[4:0];

    always_comb begin
        func = '0;
        case (i_dec.op)
            OP_OR:   func = i_x | opnd;
            OP_AND:  func = i_x & opnd;
            OP_ADD:  func = i_x + opnd;
            OP_MUL:  func = i_x * opnd;                 // Low 32 bits
            OP_RSVD: func = '0;
            OP_SHL:  func = i_x << shamt;
            OP_SLE:  func = {31'd0, $signed(i_x) <= $signed(opnd)};
            OP_EQ:   func = {31'd0, i_x == opnd};
            OP_NOR:  func = ~(i_x | opnd);
            OP_NAND: func = ~(i_x & opnd);
            OP_XOR:  func = i_x ^ opnd;
            OP_SUB:  func = i_x - opnd;
            OP_XNOR: func = i_x ^ ~opnd;
            OP_SHR:  func = i_x >> shamt;
            OP_SGT:  func = {31'd0, $signed(i_x) > $signed(opnd)};
            OP_NE:   func = {31'd0, i_x != opnd};
            default: func = '0;
        endcase
    end

    // Comparisons have already been reduced to 0 or 1
    assign o_rhs = func + addend;

endmodule

//--- design/core_seq.sv
`timescale 1ns/1ps

module core_seq #(
    parameter cpu_pkg::word_t RESET_VECTOR = cpu_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic                   reset_n,    // Clock
    input  logic                   i_reset_n,  // Sync reset, active high
    input  cpu_pkg::decoded_insn_t i_dec,
    input  cpu_pkg::word_t         i_rhs,
    input  cpu_pkg::word_t         i_z,
    input  logic                   i_fetch_valid,
    input  cpu_pkg::word_t         i_fetch_data,
    input  logic                   i_mem_valid,
    input  cpu_pkg::word_t         i_mem_rdata,
    output cpu_pkg::word_t         o_insn,
    output cpu_pkg::word_t         o_pc,
    output logic                   o_rf_we,
    output cpu_pkg::reg_idx_t      o_rf_idx,
    output cpu_pkg::word_t         o_rf_data,
    output logic                   o_fetch_req,
    output cpu_pkg::word_t         o_fetch_addr,
    output logic                   o_mem_req,
    output logic                   o_mem_we,
    output cpu_pkg::word_t         o_mem_addr,
    output cpu_pkg::word_t         o_mem_wdata,
    output logic                   o_halt
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH, S_FETCH_WAIT, S_EXEC, S_MEM, S_WB, S_HALT
    } state_e;

    state_e state;
    word_t  pc_q;
    word_t  insn_q;
    word_t  result_q;     // rhs, or load data once it arrives
    word_t  mem_addr_q;
    word_t  mem_wdata_q;
    logic   fetch_req_q;
    logic   mem_req_q;
    logic   mem_we_q;
    logic   halt_q;
    logic   wb_write;
    logic   is_store;

    assign is_store = (i_dec.deref == DEREF_STORE_Z) || (i_dec.deref == DEREF_STORE_R);

    // Plain and load results go to Z, r0 excluded
    assign wb_write = (i_dec.insn_class == CLASS_NORMAL) && !is_store
                   && (i_dec.z != REG_ZERO);

    always_ff @(posedge reset_n) begin
        if (i_reset_n) begin
            state       <= S_FETCH;
            pc_q        <= RESET_VECTOR;
            fetch_req_q <= 1'b0;
            mem_req_q   <= 1'b0;
            mem_we_q    <= 1'b0;
            halt_q      <= 1'b0;
        end else begin
            fetch_req_q <= 1'b0;  // Strobes drop after one cycle
            mem_req_q   <= 1'b0;
            mem_we_q    <= 1'b0;
            case (state)
                S_FETCH: begin    // Only entered out of reset
                    fetch_req_q <= 1'b1;
                    state       <= S_FETCH_WAIT;
                end
                S_FETCH_WAIT: if (i_fetch_valid) state <= S_EXEC;
                S_EXEC: begin
                    if (i_dec.insn_class == CLASS_ILLEGAL) begin
                        halt_q <= 1'b1;
                        state  <= S_HALT;
                    end else if (i_dec.deref != DEREF_PLAIN) begin
                        mem_req_q <= 1'b1;
                        mem_we_q  <= is_store;
                        state     <= S_MEM;
                    end else begin
                        state <= S_WB;  // No-op class lands here too
                    end
                end
                S_MEM: begin
                    if (is_store || i_mem_valid) state <= S_WB;
                end
                S_WB: begin
                    if (wb_write && (i_dec.z == REG_PC)) begin
                        pc_q <= result_q;   // Jump
                    end else begin
                        pc_q <= pc_q + 32'd1;
                    end
                    fetch_req_q <= 1'b1;    // Next fetch starts right away
                    state       <= S_FETCH_WAIT;
                end
                S_HALT: state <= S_HALT;    // Held until reset
                default: state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge reset_n) begin
        if ((state == S_FETCH_WAIT) && i_fetch_valid) begin
            insn_q <= i_fetch_data;
        end
        if (state == S_EXEC) begin
            result_q <= i_rhs;
            // Store-to-Z puts rhs at [Z], the others address through rhs
            mem_addr_q  <= (i_dec.deref == DEREF_STORE_Z) ? i_z : i_rhs;
            mem_wdata_q <= (i_dec.deref == DEREF_STORE_Z) ? i_rhs : i_z;
        end
        if ((state == S_MEM) && (i_dec.deref == DEREF_LOAD) && i_mem_valid) begin
            result_q <= i_mem_rdata;
        end
    end

    assign o_insn       = insn_q;
    assign o_pc         = pc_q;
    assign o_rf_we      = (state == S_WB) && wb_write;
    assign o_rf_idx     = i_dec.z;
    assign o_rf_data    = result_q;
    assign o_fetch_req  = fetch_req_q;
    assign o_fetch_addr = pc_q;
    assign o_mem_req    = mem_req_q;
    assign o_mem_we     = mem_we_q;
    assign o_mem_addr   = mem_addr_q;
    assign o_mem_wdata  = mem_wdata_q;
    assign o_halt       = halt_q;

endmodule

//--- design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::word_t RESET_VECTOR = cpu_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic           reset_n,    // Clock
    input  logic           i_reset_n,  // Sync reset, active high
    output logic           o_fetch_req,
    output cpu_pkg::word_t o_fetch_addr,
    input  logic           i_fetch_valid,
    input  cpu_pkg::word_t i_fetch_data,
    output logic           o_mem_req,
    output logic           o_mem_we,
    output cpu_pkg::word_t o_mem_addr,
    output cpu_pkg::word_t o_mem_wdata,
    input  logic           i_mem_valid,
    input  cpu_pkg::word_t i_mem_rdata,
    output logic           o_halt
);
    import cpu_pkg::*;

    decoded_insn_t dec;
    word_t         insn;
    word_t         x_val;
    word_t         y_val;
    word_t         z_val;
    word_t         rhs;
    word_t         pc;
    logic          rf_we;
    reg_idx_t      rf_idx;
    word_t         rf_data;

    core_seq #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_seq (
        .reset_n       (reset_n),
        .i_reset_n     (i_reset_n),
        .i_dec         (dec),
        .i_rhs         (rhs),
        .i_z           (z_val),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_data  (i_fetch_data),
        .i_mem_valid   (i_mem_valid),
        .i_mem_rdata   (i_mem_rdata),
        .o_insn        (insn),
        .o_pc          (pc),
        .o_rf_we       (rf_we),
        .o_rf_idx      (rf_idx),
        .o_rf_data     (rf_data),
        .o_fetch_req   (o_fetch_req),
        .o_fetch_addr  (o_fetch_addr),
        .o_mem_req     (o_mem_req),
        .o_mem_we      (o_mem_we),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata),
        .o_halt        (o_halt)
    );

    insn_decode u_decode (
        .i_insn (insn),
        .o_dec  (dec)
    );

    reg_file u_regs (
        .reset_n   (reset_n),
        .i_reset_n (i_reset_n),
        .i_x_idx   (dec.x),
        .i_y_idx   (dec.y),
        .i_z_idx   (dec.z),
        .i_pc      (pc),
        .i_we      (rf_we),
        .i_wr_idx  (rf_idx),
        .i_wr_data (rf_data),
        .o_x       (x_val),
        .o_y       (y_val),
        .o_z       (z_val)
    );

    exec_unit u_exec (
        .i_dec (dec),
        .i_x   (x_val),
        .i_y   (y_val),
        .o_rhs (rhs)
    );

endmodule

//--- dv/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

localparam logic [1:0] M_PLAIN = 2'b00;
localparam logic [1:0] M_LOAD  = 2'b01;
localparam logic [1:0] M_ST_Z  = 2'b10;  // [Z] gets rhs
localparam logic [1:0] M_ST_R  = 2'b11;  // [rhs] gets Z
localparam logic [3:0] K_OR    = 4'h0;
localparam logic [3:0] K_ADD   = 4'h2;

function automatic word_t encode_insn(input logic t, input logic [1:0] mode,
                                      input logic [3:0] z, input logic [3:0] x,
                                      input logic [3:0] y, input logic [3:0] op,
                                      input logic [11:0] imm);
    return {1'b0, t, mode, z, x, y, op, imm};
endfunction

function automatic word_t op_result(input logic [3:0] op, input word_t a, input word_t b);
    int signed sa;
    int signed sb;
    sa = a;
    sb = b;
    case (op)
        4'h0: return a | b;
        4'h1: return a & b;
        4'h2: return a + b;
        4'h3: return a * b;                 // Low word of the product
        4'h4: return 32'd0;                 // Reserved
        4'h5: return a << b[4:0];
        4'h6: return (sa <= sb) ? 32'd1 : 32'd0;
        4'h7: return (a == b) ? 32'd1 : 32'd0;
        4'h8: return ~(a | b);
        4'h9: return ~(a & b);
        4'ha: return a ^ b;
        4'hb: return a - b;
        4'hc: return ~(a ^ b);
        4'hd: return a >> b[4:0];
        4'he: return (sa > sb) ? 32'd1 : 32'd0;
        default: return (a != b) ? 32'd1 : 32'd0;
    endcase
endfunction

function automatic word_t expect_rhs(input logic t, input logic [3:0] op, input word_t x,
                                     input word_t y, input logic [11:0] imm);
    word_t imm_sx;
    imm_sx = imm[11] ? word_t'(imm) - 32'd4096 : word_t'(imm);
    if (t) return op_result(op, x, imm_sx) + y;
    return op_result(op, x, y) + imm_sx;
endfunction

task automatic push_store(input word_t addr, input word_t data);
    mem_write_t wr;
    wr.addr = addr;
    wr.data = data;
    exp_stores.push_back(wr);
endtask

task automatic expect_sequential_fetches();
    foreach (prog[i]) begin
        exp_fetches.push_back(RV + word_t'(i));
    end
endtask

task automatic check_all();
    check_value("o_halt", {31'd0, halt}, 32'd1);
    check_value("fetch count", word_t'(fetch_log.size()), word_t'(exp_fetches.size()));
    foreach (exp_fetches[i]) begin
        check_value($sformatf("o_fetch_addr[%0d]", i), fetch_log[i], exp_fetches[i]);
    end
    check_value("store count", word_t'(store_log.size()), word_t'(exp_stores.size()));
    foreach (exp_stores[i]) begin
        check_value($sformatf("o_mem_addr[%0d]", i), store_log[i].addr, exp_stores[i].addr);
        check_value($sformatf("o_mem_wdata[%0d]", i), store_log[i].data, exp_stores[i].data);
    end
    exp_fetches.delete();
    exp_stores.delete();
endtask

task automatic test_sequential_and_halt();
    prog.delete();
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd1, 4'd0, 4'd0, K_OR, 12'h05a));
    prog.push_back(32'h8000_0000);      // No-op
    prog.push_back(32'hb1ff_ffff);      // No-op with store bits and Z=1
    prog.push_back(encode_insn(1'b0, M_ST_R, 4'd1, 4'd0, 4'd0, K_OR, 12'h011));
    prog.push_back(32'he000_0001);      // No-op right before the halt
    prog.push_back(ILLEGAL);
    load_program();
    run_program();
    expect_sequential_fetches();
    push_store(32'h11, 32'h5a);
    check_all();
endtask

// Every op in both types over a few edge operand sets
task automatic test_alu_ops();
    word_t       val [16];
    logic [3:0]  sx [4];
    logic [3:0]  sy [4];
    logic [11:0] si [4];
    for (int r = 0; r < 16; r++) begin
        val[r] = 32'd0;
    end
    val[1] = 32'h8000_0000;
    val[2] = 32'hffff_ffff;
    val[3] = 32'h7fff_ffff;
    val[4] = 32'h0000_0001;
    val[5] = 32'h0000_0005;
    val[6] = 32'h1234_5678;
    sx[0] = 4'd1;
    sy[0] = 4'd2;
    si[0] = 12'h7ff;
    sx[1] = 4'd3;
    sy[1] = 4'd4;
    si[1] = 12'h800;
    sx[2] = 4'd5;
    sy[2] = 4'd5;
    si[2] = 12'h003;
    sx[3] = 4'd2;
    sy[3] = 4'd6;
    si[3] = 12'hfe1;
    prog.delete();
    for (int r = 1; r < 7; r++) begin
        prog.push_back(encode_insn(1'b0, M_LOAD, 4'(r), 4'd0, 4'd0, K_OR, 12'h010 + 12'(r)));
    end
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd10, 4'd0, 4'd0, K_OR, 12'h080));
    for (int op = 0; op < 16; op++) begin
        for (int t = 0; t < 2; t++) begin
            for (int s = 0; s < 4; s++) begin
                prog.push_back(encode_insn(1'(t), M_ST_Z, 4'd10, sx[s], sy[s], 4'(op), si[s]));
                push_store(32'h80, expect_rhs(1'(t), 4'(op), val[sx[s]], val[sy[s]], si[s]));
            end
        end
    end
    prog.push_back(ILLEGAL);
    load_program();
    for (int r = 1; r < 7; r++) begin
        dmem[8'h10 + 8'(r)] = val[r];
    end
    run_program();
    expect_sequential_fetches();
    check_all();
endtask

task automatic test_memory_modes();
    prog.delete();
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd1, 4'd0, 4'd0, K_OR, 12'h020));
    prog.push_back(encode_insn(1'b0, M_LOAD, 4'd2, 4'd1, 4'd0, K_OR, 12'h000));
    prog.push_back(encode_insn(1'b0, M_ST_R, 4'd2, 4'd0, 4'd0, K_OR, 12'h030));
    prog.push_back(encode_insn(1'b1, M_ST_Z, 4'd1, 4'd2, 4'd0, K_ADD, 12'h001));
    prog.push_back(encode_insn(1'b0, M_LOAD, 4'd3, 4'd0, 4'd0, K_OR, 12'h020));
    prog.push_back(encode_insn(1'b0, M_ST_R, 4'd3, 4'd0, 4'd0, K_OR, 12'h031));
    prog.push_back(ILLEGAL);
    load_program();
    dmem[8'h20] = 32'hcafe_f00d;
    run_program();
    expect_sequential_fetches();
    push_store(32'h30, 32'hcafe_f00d);
    push_store(32'h20, 32'hcafe_f00e);      // Loaded word plus one stored at [r1]
    push_store(32'h31, 32'hcafe_f00e);
    check_all();
endtask

task automatic test_jumps();
    prog.delete();
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd1, 4'd15, 4'd0, K_OR, 12'h000));
    prog.push_back(encode_insn(1'b0, M_ST_R, 4'd1, 4'd0, 4'd0, K_OR, 12'h050));
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd15, 4'd15, 4'd0, K_ADD, 12'h004));
    prog.push_back(ILLEGAL);                // Skipped by the jump
    prog.push_back(ILLEGAL);
    prog.push_back(ILLEGAL);
    prog.push_back(encode_insn(1'b0, M_ST_R, 4'd15, 4'd0, 4'd0, K_OR, 12'h051));
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd15, 4'd0, 4'd0, K_OR, RV[11:0] + 12'd10));
    prog.push_back(ILLEGAL);
    prog.push_back(ILLEGAL);
    prog.push_back(ILLEGAL);
    load_program();
    run_program();
    exp_fetches.push_back(RV);
    exp_fetches.push_back(RV + 32'd1);
    exp_fetches.push_back(RV + 32'd2);
    exp_fetches.push_back(RV + 32'd6);      // Relative jump lands here
    exp_fetches.push_back(RV + 32'd7);
    exp_fetches.push_back(RV + 32'd10);     // Absolute jump target
    push_store(32'h50, RV);
    push_store(32'h51, RV + 32'd6);
    check_all();
endtask

task automatic test_zero_register();
    prog.delete();
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd0, 4'd0, 4'd0, K_OR, 12'h123));
    prog.push_back(encode_insn(1'b0, M_LOAD, 4'd0, 4'd0, 4'd0, K_OR, 12'h060));
    prog.push_back(encode_insn(1'b0, M_ST_R, 4'd0, 4'd0, 4'd0, K_OR, 12'h061));
    prog.push_back(encode_insn(1'b0, M_PLAIN, 4'd1, 4'd0, 4'd0, K_ADD, 12'h007));
    prog.push_back(encode_insn(1'b0, M_ST_R, 4'd1, 4'd0, 4'd0, K_OR, 12'h062));
    prog.push_back(ILLEGAL);
    load_program();
    dmem[8'h60] = 32'hffff_ffff;
    run_program();
    expect_sequential_fetches();
    push_store(32'h61, 32'd0);
    push_store(32'h62, 32'd7);
    check_all();
endtask

`endif

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import cpu_pkg::*;

    localparam word_t RV           = 32'h0000_0040;  // Reset vector given to the DUT
    localparam int    RST_CYC      = 16;
    localparam int    CYC_PER_INSN = 200;
    localparam word_t ILLEGAL      = 32'hf000_0000;

    typedef struct packed {
        word_t addr;
        word_t data;
    } mem_write_t;

    logic  reset_n;     // Clock
    logic  reset;       // Active high, into i_reset_n
    logic  fetch_req;
    word_t fetch_addr;
    logic  fetch_valid;
    word_t fetch_data;
    logic  mem_req;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_valid;
    word_t mem_rdata;
    logic  halt;

    word_t      imem [256];
    word_t      dmem [256];
    int         lat_tab [256];  // Response delays of 1 to 3 cycles
    word_t      prog [$];
    word_t      fetch_log [$];
    mem_write_t store_log [$];
    word_t      exp_fetches [$];
    mem_write_t exp_stores [$];
    int         n_checks;
    int         cycle_budget;

    cpu_core #(
        .RESET_VECTOR (RV)
    ) u_dut (
        .reset_n       (reset_n),
        .i_reset_n     (reset),
        .o_fetch_req   (fetch_req),
        .o_fetch_addr  (fetch_addr),
        .i_fetch_valid (fetch_valid),
        .i_fetch_data  (fetch_data),
        .o_mem_req     (mem_req),
        .o_mem_we      (mem_we),
        .o_mem_addr    (mem_addr),
        .o_mem_wdata   (mem_wdata),
        .i_mem_valid   (mem_valid),
        .i_mem_rdata   (mem_rdata),
        .o_halt        (halt)
    );

    initial begin
        reset_n = 1'b0;
        forever #50 reset_n = ~reset_n;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string why);
        $display("ERROR: %s", why);
        abort_run();
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    // Instruction memory answers each fetch once after a random delay
    initial begin : fetch_model
        int    lat;
        int    idx;
        word_t addr;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        idx = 0;
        forever begin
            @(posedge reset_n);
            #1;
            fetch_valid = 1'b0;
            if (fetch_req) begin
                addr = fetch_addr;
                fetch_log.push_back(addr);
                lat = lat_tab[idx];
                idx = (idx + 1) % 256;
                repeat (lat - 1) begin
                    @(posedge reset_n);
                    #1;
                end
                fetch_valid = 1'b1;
                fetch_data  = imem[addr[7:0]];
            end
        end
    end

    // Data memory where stores land at once and loads answer late
    initial begin : data_model
        int         lat;
        int         idx;
        word_t      addr;
        mem_write_t wr;
        mem_valid = 1'b0;
        mem_rdata = '0;
        idx = 128;  // Different delays from the fetch side
        forever begin
            @(posedge reset_n);
            #1;
            mem_valid = 1'b0;
            if (mem_req && mem_we) begin
                wr.addr = mem_addr;
                wr.data = mem_wdata;
                store_log.push_back(wr);
                dmem[mem_addr[7:0]] = mem_wdata;
            end else if (mem_req) begin
                addr = mem_addr;
                lat = lat_tab[idx];
                idx = (idx + 1) % 256;
                repeat (lat - 1) begin
                    @(posedge reset_n);
                    #1;
                end
                mem_valid = 1'b1;
                mem_rdata = dmem[addr[7:0]];
            end
        end
    end

    initial begin : strobe_monitor
        logic prev_fetch;
        logic prev_mem;
        prev_fetch = 1'b0;
        prev_mem   = 1'b0;
        forever begin
            @(posedge reset_n);
            #1;
            if (fetch_req && prev_fetch) begin
                report_error("fetch strobe stayed high for two cycles");
            end
            if (mem_req && prev_mem) begin
                report_error("data strobe stayed high for two cycles");
            end
            if (fetch_req && halt) begin
                report_error("fetch strobe issued after the core halted");
            end
            prev_fetch = fetch_req;
            prev_mem   = mem_req;
        end
    end

    // Budget grows with every program that gets loaded
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge reset_n);
            cycles++;
            if (cycles > cycle_budget) begin
                report_error("the core did not halt within the cycle budget of the tests");
            end
        end
    end

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = ILLEGAL | word_t'(i);          // Stray fetches halt
            dmem[i] = 32'hd0d0_0000 | word_t'(i);
        end
        foreach (prog[i]) begin
            imem[RV[7:0] + 8'(i)] = prog[i];
        end
        cycle_budget += CYC_PER_INSN * prog.size() + RST_CYC + 8;
    endtask

    // Reset, check the first fetch, then run until halt
    task automatic run_program();
        @(posedge reset_n);
        #1;
        reset = 1'b1;
        fetch_log.delete();
        store_log.delete();
        for (int i = 0; i < RST_CYC; i++) begin
            @(posedge reset_n);
            #1;
            check_value("o_fetch_req", {31'd0, fetch_req}, 32'd0);
            check_value("o_mem_req", {31'd0, mem_req}, 32'd0);
            check_value("o_mem_we", {31'd0, mem_we}, 32'd0);
            check_value("o_halt", {31'd0, halt}, 32'd0);
        end
        reset = 1'b0;
        @(posedge reset_n);
        #1;
        check_value("o_fetch_req", {31'd0, fetch_req}, 32'd1);
        check_value("o_fetch_addr", fetch_addr, RV);
        while (halt !== 1'b1) begin
            @(posedge reset_n);
            #1;
        end
        repeat (6) begin    // Room for a stray fetch to show up
            @(posedge reset_n);
            #1;
        end
    endtask

    `include "tb_tests.svh"

    initial begin : main
        void'($urandom(32'hcfe0));
        for (int i = 0; i < 256; i++) begin
            lat_tab[i] = 1 + ($urandom % 3);
        end
        reset        = 1'b1;
        n_checks     = 0;
        cycle_budget = 0;
        test_sequential_and_halt();
        test_alu_ops();
        test_memory_modes();
        test_jumps();
        test_zero_register();
        if (n_checks > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_error("no checks were executed");
        end
    end

endmodule

//--- flist.f
+incdir+dv
design/cpu_pkg.sv
design/reg_file.sv
design/insn_decode.sv
design/exec_unit.sv
design/core_seq.sv
design/cpu_core.sv
dv/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
